/* sdram_video_pkg.sv */
`default_nettype none

package sdram_video_pkg;

   // --------------------
   // sdram command set
   // --------------------
   // code is {cs_n, ras_n, cas_n, we_n}
   typedef enum logic [3:0] {
      cmd_inhibit         = 4'b1111,
      cmd_nop             = 4'b0111,
      cmd_active          = 4'b0011,
      cmd_read            = 4'b0101,
      cmd_write           = 4'b0100,
      cmd_burst_terminate = 4'b0110,
      cmd_precharge       = 4'b0010,
      cmd_auto_refresh    = 4'b0001,
      cmd_load_mode       = 4'b0000
   } sdram_cmd_e;

   // one clock worth of sdram pins
   typedef struct packed {
      sdram_cmd_e  cmd;
      logic [10:0] a;        // row / column + a10
      logic [1:0]  ba;
      logic [15:0] dq_out;
      logic        dq_oe;    // drive dq this cycle
      logic [1:0]  dqm;      // {dqmh, dqml}
   } sdram_bus_t;

   // host side, one 32-bit word per access
   typedef struct packed {
      logic [18:0] addr;     // word address
      logic [31:0] wdata;
      logic [3:0]  be_n;     // byte mask, 0 = write byte
      logic        rd;
      logic        wr;
   } host_req_t;

   typedef struct packed {
      logic [31:0] rdata;
      logic        busy;
      logic        ack;
   } host_rsp_t;

   // --------------------
   // load-mode word
   // --------------------
   // single write, std op, cl 2, sequential, burst 4
   localparam logic [10:0] mode_word = {1'b0, 1'b1, 2'b00, 3'd2, 1'b0, 3'b010};

   // raster, in pixels and lines (640x600)
   localparam int h_total  = 800;
   localparam int h_active = 640;
   localparam int h_front  = 16;
   localparam int h_sync   = 64;
   localparam int v_total  = 618;
   localparam int v_active = 600;
   localparam int v_front  = 1;
   localparam int v_sync   = 3;

   // slot layout, 100 slots of 16 clocks per line
   localparam int slot_phases  = 16;
   localparam int refresh_slot = 83;
   localparam int phase_last   = 7;    // capture / refresh / countdown phase

endpackage

`default_nettype wire

/* raster_timing.sv */
`default_nettype none

module raster_timing #(
   parameter int refresh_slot = 83          // any slot 0..99
) (
   input  wire        clkram,
   input  wire        new_scr,
   output logic [3:0] phase,
   output logic       refresh_now,
   output logic       hsync,
   output logic       vsync,
   output logic       visible
);

   // counter runs at two clocks per pixel
   localparam int h_last  = 2 * sdram_video_pkg::h_total - 1;
   localparam int v_last  = sdram_video_pkg::v_total - 1;
   localparam int hs_beg  = 2 * (sdram_video_pkg::h_active + sdram_video_pkg::h_front);
   localparam int hs_end  = hs_beg + 2 * sdram_video_pkg::h_sync;
   localparam int vs_beg  = sdram_video_pkg::v_active + sdram_video_pkg::v_front;
   localparam int vs_end  = vs_beg + sdram_video_pkg::v_sync;
   localparam int vis_beg = sdram_video_pkg::slot_phases;  // one slot late
   localparam int vis_end = vis_beg + 2 * sdram_video_pkg::h_active;

   logic [10:0] h_cnt;   // 0..1599
   logic [9:0]  v_cnt;   // 0..617
   logic [6:0]  slot;    // 0..99

   // --------------------
   // counters
   // --------------------
   always_ff @(posedge clkram or posedge new_scr) begin
      if (new_scr) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (h_cnt == 11'(h_last)) begin
         h_cnt <= '0;
         if (v_cnt == 10'(v_last)) v_cnt <= '0;   // frame wrap
         else v_cnt <= v_cnt + 10'd1;
      end else begin
         h_cnt <= h_cnt + 11'd1;
      end
   end

   assign phase       = h_cnt[3:0];
   assign slot        = h_cnt[10:4];
   assign refresh_now = slot == 7'(refresh_slot);

   // sync and blanking decode
   assign hsync   = h_cnt >= 11'(hs_beg) && h_cnt < 11'(hs_end);
   assign vsync   = v_cnt >= 10'(vs_beg) && v_cnt < 10'(vs_end);
   assign visible = h_cnt >= 11'(vis_beg) && h_cnt < 11'(vis_end)
                    && v_cnt < 10'(sdram_video_pkg::v_active);

   // a new line always starts on a slot boundary
   assert property (@(posedge clkram) disable iff (new_scr)
      (v_cnt != $past(v_cnt)) |-> (phase == 4'd0 && slot == 7'd0));

endmodule

`default_nettype wire

/* sdram_init_seq.sv */
`default_nettype none

module sdram_init_seq (
   input  wire        clkram,
   input  wire        new_scr,
   input  wire  [3:0] phase,
   output sdram_video_pkg::sdram_bus_t init_bus,
   output logic       init_done
);

   localparam logic [4:0]  cnt_pre  = 5'd13;             // precharge slot
   localparam logic [4:0]  cnt_lmr  = 5'd2;              // load-mode slot
   localparam logic [10:0] pre_all  = 11'b100_0000_0000; // a10, all banks

   logic [4:0] count;   // slots left until ready

   // --------------------
   // power-up countdown
   // --------------------
   always_ff @(posedge clkram or posedge new_scr) begin
      if (new_scr) begin
         count <= 5'd31;
      end else if (phase == 4'(sdram_video_pkg::phase_last) && count != 5'd0) begin
         count <= count - 5'd1;                           // once per slot
      end
   end

   assign init_done = count == 5'd0;

   // commands, only at the start of a slot
   always_comb begin
      init_bus.cmd    = sdram_video_pkg::cmd_nop;
      init_bus.a      = (count == cnt_pre) ? pre_all : sdram_video_pkg::mode_word;
      init_bus.ba     = 2'b00;
      init_bus.dq_out = '0;
      init_bus.dq_oe  = 1'b0;
      init_bus.dqm    = 2'b11;                            // masked during init
      if (phase == 4'd0) begin
         if (count == cnt_pre) init_bus.cmd = sdram_video_pkg::cmd_precharge;
         else if (count == cnt_lmr) init_bus.cmd = sdram_video_pkg::cmd_load_mode;
      end
   end

   // nothing but the init pair before ready
   assert property (@(posedge clkram) disable iff (new_scr)
      !init_done |-> init_bus.cmd inside {sdram_video_pkg::cmd_nop,
                                          sdram_video_pkg::cmd_precharge,
                                          sdram_video_pkg::cmd_load_mode});

endmodule

`default_nettype wire

/* host_port.sv */
`default_nettype none

module host_port (
   input  wire         clkram,
   input  wire         new_scr,
   input  wire sdram_video_pkg::host_req_t host_req,
   input  wire  [3:0]  phase,
   input  wire         init_done,
   input  wire         lo_valid,     // low half read back
   input  wire         hi_valid,     // access finished
   input  wire  [15:0] rd_word,
   output sdram_video_pkg::host_req_t req_q,
   output sdram_video_pkg::host_rsp_t host_rsp
);

   logic        req_on;    // rd or wr held by host
   logic        ack_q;
   logic [31:0] rdata_q;

   assign req_on = host_req.rd | host_req.wr;

   // --------------------
   // request capture
   // --------------------
   always_ff @(posedge clkram or posedge new_scr) begin
      if (new_scr) begin
         req_q <= '0;
      end else if (phase == 4'(sdram_video_pkg::phase_last)) begin
         if (init_done && !ack_q) begin
            req_q <= host_req;          // slot runs this one
         end else begin
            req_q.rd <= 1'b0;           // idle slot
            req_q.wr <= 1'b0;
         end
      end
   end

   // read word, two halves
   always_ff @(posedge clkram) begin
      if (lo_valid) rdata_q[15:0] <= rd_word;
      if (hi_valid) rdata_q[31:16] <= rd_word;
   end

   // --------------------
   // ack
   // --------------------
   always_ff @(posedge clkram or posedge new_scr) begin
      if (new_scr) begin
         ack_q <= 1'b0;
      end else begin
         if (!req_on) ack_q <= 1'b0;   // falls a cycle after release
         if (hi_valid) ack_q <= 1'b1;
      end
   end

   always_comb begin
      host_rsp.rdata = rdata_q;
      host_rsp.busy  = req_on & ~ack_q;  // also high while init runs
      host_rsp.ack   = ack_q;
   end

   // completion only for a request still held
   assert property (@(posedge clkram) disable iff (new_scr)
      $rose(ack_q) |-> $past(req_on));

endmodule

`default_nettype wire

/* sdram_cmd_seq.sv */
`default_nettype none

module sdram_cmd_seq (
   input  wire         clkram,
   input  wire         new_scr,
   input  wire  [3:0]  phase,
   input  wire         refresh_now,
   input  wire         init_done,
   input  wire sdram_video_pkg::sdram_bus_t init_bus,
   input  wire sdram_video_pkg::host_req_t  req_q,
   input  wire  [15:0] sdram_dq_in,
   output sdram_video_pkg::sdram_bus_t bus,
   output logic        lo_valid,
   output logic        hi_valid,
   output logic [15:0] rd_word
);

   // host slot layout
   localparam logic [3:0] ph_act_lo = 4'd8;    // active bank 0
   localparam logic [3:0] ph_rw_lo  = 4'd10;   // low half rd/wr
   localparam logic [3:0] ph_act_hi = 4'd11;   // active bank 1
   localparam logic [3:0] ph_get_lo = 4'd12;
   localparam logic [3:0] ph_rw_hi  = 4'd13;   // high half rd/wr
   localparam logic [3:0] ph_get_hi = 4'd15;

   sdram_video_pkg::sdram_bus_t bus_d;    // next pins
   logic                        access;   // host access in this slot
   logic [10:0]                 row;
   logic [7:0]                  col;

   // --------------------
   // command builders
   // --------------------
   function automatic sdram_video_pkg::sdram_bus_t idle_bus();
      sdram_video_pkg::sdram_bus_t b;
      b.cmd    = sdram_video_pkg::cmd_nop;
      b.a      = '0;
      b.ba     = 2'b00;
      b.dq_out = '0;
      b.dq_oe  = 1'b0;
      b.dqm    = 2'b11;
      return b;
   endfunction

   function automatic sdram_video_pkg::sdram_bus_t activate(
      input logic [1:0] ba, input logic [10:0] r);
      sdram_video_pkg::sdram_bus_t b;
      b     = idle_bus();
      b.cmd = sdram_video_pkg::cmd_active;
      b.ba  = ba;
      b.a   = r;
      return b;
   endfunction

   // one 16-bit half, always with auto-precharge
   function automatic sdram_video_pkg::sdram_bus_t rw_half(
      input logic [1:0] ba, input logic [7:0] c, input logic wr,
      input logic [15:0] data, input logic [1:0] be_n);
      sdram_video_pkg::sdram_bus_t b;
      b    = idle_bus();
      b.ba = ba;
      b.a  = {3'b100, c};                    // a10 high
      if (wr) begin
         b.cmd    = sdram_video_pkg::cmd_write;
         b.dq_out = data;
         b.dq_oe  = 1'b1;
         b.dqm    = be_n;                    // masked bytes kept
      end else begin
         b.cmd = sdram_video_pkg::cmd_read;
         b.dqm = 2'b00;
      end
      return b;
   endfunction

   assign row    = req_q.addr[18:8];
   assign col    = req_q.addr[7:0];
   assign access = init_done && !refresh_now && (req_q.rd || req_q.wr);

   // --------------------
   // per-phase select
   // --------------------
   always_comb begin
      bus_d = idle_bus();
      if (!init_done) begin
         bus_d = init_bus;                   // power-up owns the bus
      end else if (refresh_now) begin
         if (phase == 4'(sdram_video_pkg::phase_last))
            bus_d.cmd = sdram_video_pkg::cmd_auto_refresh;
      end else if (access) begin
         case (phase)
            ph_act_lo: bus_d = activate(2'b00, row);
            ph_rw_lo:  bus_d = rw_half(2'b00, col, req_q.wr, req_q.wdata[15:0],
                                       req_q.be_n[1:0]);
            ph_act_hi: bus_d = activate(2'b01, row);
            ph_rw_hi:  bus_d = rw_half(2'b01, col, req_q.wr, req_q.wdata[31:16],
                                       req_q.be_n[3:2]);
            default:   bus_d = idle_bus();
         endcase
      end
   end

   always_ff @(posedge clkram or posedge new_scr) begin
      if (new_scr) bus <= idle_bus();
      else bus <= bus_d;
   end

   // --------------------
   // read data, cl 2
   // --------------------
   always_ff @(posedge clkram or posedge new_scr) begin
      if (new_scr) begin
         lo_valid <= 1'b0;
         hi_valid <= 1'b0;
      end else begin
         lo_valid <= access && req_q.rd && phase == ph_get_lo;
         hi_valid <= access && phase == ph_get_hi;  // end of rd or wr
      end
   end

   always_ff @(posedge clkram) begin
      if (access && (phase == ph_get_lo || phase == ph_get_hi)) rd_word <= sdram_dq_in;
   end

   // dq driven only for a host write
   assert property (@(posedge clkram) disable iff (new_scr)
      bus.dq_oe |-> (bus.cmd == sdram_video_pkg::cmd_write) && $past(req_q.wr));

endmodule

`default_nettype wire

/* sdram_video_ctrl.sv */
`default_nettype none

module sdram_video_ctrl #(
   parameter int refresh_slot = sdram_video_pkg::refresh_slot
) (
   input  wire                        clkram,
   input  wire                        new_scr,      // async reset, high
   input  wire sdram_video_pkg::host_req_t host_req,
   output sdram_video_pkg::host_rsp_t host_rsp,
   output logic                       init,         // sdram ready
   output logic                       hsync,
   output logic                       vsync,
   output logic                       visible,
   // sdram pins
   output logic [10:0]                sdram_a,
   output logic [1:0]                 sdram_ba,
   output logic                       sdram_cs_n,
   output logic                       sdram_ras_n,
   output logic                       sdram_cas_n,
   output logic                       sdram_we_n,
   output logic                       sdram_dqml,
   output logic                       sdram_dqmh,
   inout  wire  [15:0]                sdram_dq
);

   logic [3:0]                 phase;       // clock within slot
   logic                       refresh_now; // whole refresh slot
   logic                       init_done;
   logic                       lo_valid;
   logic                       hi_valid;
   logic [15:0]                rd_word;
   sdram_video_pkg::sdram_bus_t init_bus;
   sdram_video_pkg::sdram_bus_t bus;        // registered pins
   sdram_video_pkg::host_req_t  req_q;

   raster_timing #(
      .refresh_slot (refresh_slot)
   ) i_raster (
      .clkram, .new_scr, .phase, .refresh_now, .hsync, .vsync, .visible
   );

   sdram_init_seq i_init (
      .clkram, .new_scr, .phase, .init_bus, .init_done
   );

   host_port i_host (
      .clkram, .new_scr, .host_req, .phase, .init_done,
      .lo_valid, .hi_valid, .rd_word, .req_q, .host_rsp
   );

   sdram_cmd_seq i_cmd (
      .clkram, .new_scr, .phase, .refresh_now, .init_done, .init_bus, .req_q,
      .sdram_dq_in (sdram_dq),
      .bus, .lo_valid, .hi_valid, .rd_word
   );

   // --------------------
   // pins
   // --------------------
   assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = bus.cmd;
   assign sdram_a    = bus.a;
   assign sdram_ba   = bus.ba;
   assign sdram_dqml = bus.dqm[0];
   assign sdram_dqmh = bus.dqm[1];
   assign sdram_dq   = bus.dq_oe ? bus.dq_out : 16'hzzzz;  // only during write
   assign init       = init_done;

endmodule

`default_nettype wire

/* tb_sdram_model.sv */
`default_nettype none

module tb_sdram_model (
   input  wire        clkram,
   input  wire [10:0] a,
   input  wire [1:0]  ba,
   input  wire        cs_n,
   input  wire        ras_n,
   input  wire        cas_n,
   input  wire        we_n,
   input  wire        dqml,
   input  wire        dqmh,
   inout  wire [15:0] dq
);

   logic [15:0] mem [logic [19:0]];   // sparse, {bank, row, col}
   logic [10:0] open_row [0:1];       // banks 0 and 1 only
   logic [3:0]  cmd;
   logic [19:0] loc;
   logic [15:0] rd_data;
   logic        rd_oe = 1'b0;

   assign cmd = {cs_n, ras_n, cas_n, we_n};
   assign loc = {ba[0], open_row[ba[0]], a[7:0]};
   assign dq  = rd_oe ? rd_data : 16'hzzzz;

   // unwritten words get a pattern of the whole location
   function automatic logic [15:0] word_at(input logic [19:0] l);
      if (mem.exists(l)) return mem[l];
      return l[15:0] ^ {4{l[19:16]}};
   endfunction

   always @(posedge clkram) begin
      logic [15:0] w;
      rd_oe <= 1'b0;                              // one word per read
      if (cmd == sdram_video_pkg::cmd_active) open_row[ba[0]] <= a;
      if (cmd == sdram_video_pkg::cmd_write) begin
         w = word_at(loc);
         if (!dqml) w[7:0] = dq[7:0];             // masked bytes kept
         if (!dqmh) w[15:8] = dq[15:8];
         mem[loc] = w;
      end
      if (cmd == sdram_video_pkg::cmd_read) begin
         rd_data <= word_at(loc);
         rd_oe   <= 1'b1;                         // cl 2 counted from issue
      end
   end

endmodule

`default_nettype wire

/* tb_sdram_video_ctrl.sv */
`default_nettype none

module tb_sdram_video_ctrl;

   localparam int drive_dly   = 1;
   localparam int h_clocks    = 2 * sdram_video_pkg::h_total;
   localparam int cycle_limit = 3 * h_clocks * sdram_video_pkg::v_total;  // three frames
   localparam int ack_limit   = 64 * sdram_video_pkg::slot_phases;        // init plus slack
   localparam int refresh_h   = sdram_video_pkg::refresh_slot * sdram_video_pkg::slot_phases
                                + sdram_video_pkg::phase_last + 1;        // one clock late on pins

   logic                       clkram;
   logic                       new_scr;
   sdram_video_pkg::host_req_t host_req;
   sdram_video_pkg::host_rsp_t host_rsp;
   logic                       init;
   logic                       hsync;
   logic                       vsync;
   logic                       visible;
   logic [10:0]                sdram_a;
   logic [1:0]                 sdram_ba;
   logic                       cs_n, ras_n, cas_n, we_n, dqml, dqmh;
   wire  [15:0]                sdram_dq;
   logic [3:0]                 pin_cmd;
   logic                       req_on;
   logic [15:0]                lfsr = 16'd24935;
   int                         h_tb, pin_slot, cycles = 0, err_value = 0, err_other = 0;
   int                         n_pre, n_lmr, n_ref, refresh_lines, vs_falls, vis_lines;
   int                         hs_run, vs_run, vis_run;
   logic                       init_q, hs_q, vs_q, vis_q, line_ready;

   sdram_video_ctrl i_dut (
      .clkram, .new_scr, .host_req, .host_rsp, .init, .hsync, .vsync, .visible,
      .sdram_a, .sdram_ba, .sdram_cs_n (cs_n), .sdram_ras_n (ras_n), .sdram_cas_n (cas_n),
      .sdram_we_n (we_n), .sdram_dqml (dqml), .sdram_dqmh (dqmh), .sdram_dq
   );

   tb_sdram_model i_mem (
      .clkram, .a (sdram_a), .ba (sdram_ba), .cs_n, .ras_n, .cas_n, .we_n, .dqml, .dqmh,
      .dq (sdram_dq)
   );

   assign pin_cmd  = {cs_n, ras_n, cas_n, we_n};
   assign req_on   = host_req.rd | host_req.wr;
   assign pin_slot = ((h_tb + h_clocks - 1) % h_clocks) / sdram_video_pkg::slot_phases;

   initial begin
      clkram = 1'b0;
      forever #2 clkram = ~clkram;
   end

   // fibonacci lfsr, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      int i;
      v = '0;
      for (i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   // byte i from new where be_n[i] is 0
   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                               input logic [3:0] be_n);
      logic [31:0] m;
      m = old_w;
      for (int i = 0; i < 4; i++) if (!be_n[i]) m[8*i +: 8] = new_w[8*i +: 8];
      return m;
   endfunction

   task automatic report_counts();
      $display("errors: %0d wrong values, %0d other failures", err_value, err_other);
   endtask

   // --------------------
   // host handshake
   // --------------------
   task automatic host_access(input logic wr, input logic [18:0] addr, input logic [31:0] wdata,
                              input logic [3:0] be_n, input int hold, output logic [31:0] rdata);
      int waited;
      waited         = 0;
      host_req.addr  = addr;
      host_req.wdata = wdata;
      host_req.be_n  = be_n;
      host_req.wr    = wr;
      host_req.rd    = !wr;
      while (!host_rsp.ack && waited < ack_limit) begin
         @(posedge clkram);
         #drive_dly;
         waited++;
      end
      assert (host_rsp.ack) else begin
         err_other++;
         $display("no ack within %0d cycles for access at address %h", ack_limit, addr);
      end
      repeat (hold) begin           // held past ack, must not run again
         @(posedge clkram);
         #drive_dly;
      end
      rdata       = host_rsp.rdata;
      host_req.rd = 1'b0;
      host_req.wr = 1'b0;
      @(posedge clkram);
      #drive_dly;
   endtask

   initial begin
      logic [31:0] r, d0, d1, rdata, expect_w;
      int          n;
      new_scr  = 1'b1;
      host_req = '0;
      repeat (16) @(posedge clkram);
      #drive_dly new_scr = 1'b0;
      for (n = 0; n < 8; n++) begin   // first one lands during init
         take_bits(19, r);
         take_bits(32, d0);
         host_access(1'b1, r[18:0], d0, 4'h0, 0, rdata);
         take_bits(32, d1);
         take_bits(9, expect_w);
         host_access(1'b1, r[18:0], d1, expect_w[3:0], 16 + int'(expect_w[8:4]), rdata);
         expect_w = merge_bytes(d0, d1, expect_w[3:0]);
         host_access(1'b0, r[18:0], '0, 4'hf, 0, rdata);
         assert (rdata == expect_w) else begin
            err_value++;
            $display("Fail %0t host_rsp.rdata got %h expected %h", $time, rdata, expect_w);
         end
      end
      while (vs_falls < 2) @(posedge clkram);   // two frames of raster checks
      assert (n_lmr == 1 && refresh_lines > 0) else begin
         err_other++;
         $display("init sequence or refresh checks were never reached");
      end
      report_counts();
      if (err_value + err_other == 0) $display("STATUS: PASS");
      else $display("STATUS: FAIL");
      $finish;
   end

   always @(posedge clkram) begin
      cycles <= cycles + 1;
      if (cycles == cycle_limit) begin
         $display("timeout, run still going after %0d cycles", cycle_limit);
         report_counts();
         $display("STATUS: FAIL");
         $finish;
      end
   end

   // reference line position, same reset as the raster
   always @(posedge clkram or posedge new_scr) begin
      if (new_scr) h_tb <= 0;
      else if (h_tb == h_clocks - 1) h_tb <= 0;
      else h_tb <= h_tb + 1;
   end

   // --------------------
   // protocol properties
   // --------------------
   assert property (@(posedge clkram) disable iff (new_scr)
      host_rsp.busy == (req_on && !host_rsp.ack))
      else begin
         err_value++;
         $display("Fail %0t host_rsp.busy got %b expected %b", $time, $sampled(host_rsp.busy),
                  $sampled(req_on && !host_rsp.ack));
      end
   assert property (@(posedge clkram) disable iff (new_scr)
      $past(host_rsp.ack) |-> host_rsp.ack == $past(req_on))   // held, then one-cycle fall
      else begin
         err_value++;
         $display("Fail %0t host_rsp.ack got %b expected %b", $time, $sampled(host_rsp.ack),
                  $past(req_on));
      end
   assert property (@(posedge clkram) disable iff (new_scr)
      host_rsp.ack |-> pin_cmd != sdram_video_pkg::cmd_active)
      else begin
         err_other++;
         $display("row opened at %0t while ack was still high", $time);
      end
   assert property (@(posedge clkram) disable iff (new_scr)
      pin_cmd == sdram_video_pkg::cmd_auto_refresh |-> h_tb == refresh_h)
      else begin
         err_value++;
         $display("Fail %0t refresh_h got %0d expected %0d", $time, $sampled(h_tb), refresh_h);
      end
   assert property (@(posedge clkram) disable iff (new_scr)
      pin_cmd == sdram_video_pkg::cmd_active |-> pin_slot != sdram_video_pkg::refresh_slot)
      else begin
         err_other++;
         $display("active command inside the refresh slot at %0t", $time);
      end

   // --------------------
   // init, refresh and raster
   // --------------------
   always @(posedge clkram) begin
      if (new_scr) begin
         {n_pre, n_lmr, n_ref, refresh_lines, vs_falls, vis_lines} = '0;
         {hs_run, vs_run, vis_run} = '0;
         {init_q, hs_q, vs_q, vis_q, line_ready} = '0;
      end else begin
         if (!init) begin
            assert (pin_cmd inside {sdram_video_pkg::cmd_nop, sdram_video_pkg::cmd_precharge,
                                    sdram_video_pkg::cmd_load_mode}) else begin
               err_other++;
               $display("command %b issued at %0t before init", pin_cmd, $time);
            end
            if (pin_cmd == sdram_video_pkg::cmd_precharge) n_pre++;
            if (pin_cmd == sdram_video_pkg::cmd_load_mode) begin
               assert (sdram_a == sdram_video_pkg::mode_word) else begin
                  err_value++;
                  $display("Fail %0t sdram_a got %h expected %h", $time, sdram_a,
                           sdram_video_pkg::mode_word);
               end
               assert (n_pre == 1 && n_lmr == 0) else begin
                  err_other++;
                  $display("load-mode at %0t not after exactly one precharge", $time);
               end
               n_lmr++;
            end
         end
         assert (!(init && !init_q) || (n_pre == 1 && n_lmr == 1)) else begin
            err_other++;
            $display("init rose without one precharge and one load-mode");
         end
         if (pin_cmd == sdram_video_pkg::cmd_auto_refresh) n_ref++;
         if (h_tb == h_clocks - 1) begin                    // end of line
            assert (!line_ready || n_ref == 1) else begin
               err_value++;
               $display("Fail %0t refreshes_per_line got %0d expected 1", $time, n_ref);
            end
            if (line_ready) refresh_lines++;
            line_ready = init;
            n_ref      = 0;
         end
         if (hsync) hs_run++;
         else if (hs_q) begin
            assert (hs_run == 2 * sdram_video_pkg::h_sync) else begin
               err_value++;
               $display("Fail %0t hsync_clocks got %0d expected %0d", $time, hs_run,
                        2 * sdram_video_pkg::h_sync);
            end
            hs_run = 0;
         end
         if (visible) vis_run++;
         else if (vis_q) begin
            assert (vis_run == 2 * sdram_video_pkg::h_active) else begin
               err_value++;
               $display("Fail %0t visible_clocks got %0d expected %0d", $time, vis_run,
                        2 * sdram_video_pkg::h_active);
            end
            vis_run = 0;
            vis_lines++;
         end
         if (vsync && !vs_q) begin                          // frame boundary
            assert (vis_lines == sdram_video_pkg::v_active) else begin
               err_value++;
               $display("Fail %0t visible_lines got %0d expected %0d", $time, vis_lines,
                        sdram_video_pkg::v_active);
            end
            vis_lines = 0;
         end
         if (vsync) vs_run++;
         else if (vs_q) begin
            assert (vs_run == sdram_video_pkg::v_sync * h_clocks) else begin
               err_value++;
               $display("Fail %0t vsync_clocks got %0d expected %0d", $time, vs_run,
                        sdram_video_pkg::v_sync * h_clocks);
            end
            vs_run = 0;
            vs_falls++;
         end
         init_q = init;
         hs_q   = hsync;
         vs_q   = vsync;
         vis_q  = visible;
      end
   end

endmodule

`default_nettype wire

/* sdram_video_ctrl.f */
sdram_video_pkg.sv
raster_timing.sv
sdram_init_seq.sv
host_port.sv
sdram_cmd_seq.sv
sdram_video_ctrl.sv
tb_sdram_model.sv
tb_sdram_video_ctrl.sv

/* Bender.yml */
package:
  name: sdram_video_ctrl

sources:
  - sdram_video_pkg.sv
  - raster_timing.sv
  - sdram_init_seq.sv
  - host_port.sv
  - sdram_cmd_seq.sv
  - sdram_video_ctrl.sv
  - target: test
    files:
      - tb_sdram_model.sv
      - tb_sdram_video_ctrl.sv
